// ==== ctl_reg_loader.f ====
+incdir+include
source/ctl_loader_pkg.sv
source/ctl_seq_if.sv
source/ctl_fsm.sv
source/burst_counter.sv
source/ctl_flag_reg.sv
source/settings_capture.sv
source/ctl_bus_port.sv
source/ctl_loader_top.sv
bench/tb_clk_gen.sv
bench/ctl_loader_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench; a failing run exits with a nonzero status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module ctl_loader_tb \
    -f ctl_reg_loader.f --Mdir obj_dir -o ctl_loader_sim

./obj_dir/ctl_loader_sim

// ==== bench/ctl_loader_tb.sv ====
`timescale 1ns/1ps
`include "ctl_loader_settings.svh"

module ctl_loader_tb import ctl_loader_pkg::*; ();

    localparam int num_rows    = 8;
    localparam int cycle_limit = 200 * num_rows + 100;
    localparam int poll_window = 2 * 4 + `CTL_RD_LATENCY; // Two poll loops plus the read path

    localparam ctl_flags_t f_sil    = ctl_flags_t'(1) << `CTL_FLAG_SILENCER_SET;
    localparam ctl_flags_t f_pwe    = ctl_flags_t'(1) << `CTL_FLAG_PWE_SET;
    localparam ctl_flags_t f_sync   = ctl_flags_t'(1) << `CTL_FLAG_SYNC_SET;
    localparam ctl_flags_t f_fan    = ctl_flags_t'(1) << `CTL_FLAG_FORCE_FAN;
    localparam ctl_flags_t set_mask = f_sil | f_pwe | f_sync;

    typedef struct packed {
        ctl_flags_t flags;
        logic       thermo;
        logic [2:0] exp_blk; // Bit 0 silencer, bit 1 pulse-width encoder, bit 2 sync
    } row_t;

    logic       CLK;
    logic       arst_n;
    logic       thermo;
    cnt_word_t  ram_dout = '0;
    logic       ram_we;
    cnt_addr_t  ram_addr;
    cnt_word_t  ram_din;
    logic       force_fan;
    logic       silencer_mode;
    rate_t      silencer_rate_intensity;
    rate_t      silencer_rate_phase;
    rate_t      silencer_steps_intensity;
    rate_t      silencer_steps_phase;
    logic       silencer_update;
    cnt_word_t  pwe_full_width_start;
    logic       pwe_update;
    sync_time_t sync_time;
    base_cnt_t  sync_base_cnt;
    logic       sync_update;

    cnt_word_t  mem [256];
    cnt_addr_t  rd_addr_q = '0;
    cnt_word_t  rd_data_q = '0;
    logic       host_we   = 1'b0;
    cnt_addr_t  host_addr = '0;
    cnt_word_t  host_data = '0;
    int         cycle_cnt = 0;

    row_t       rows [num_rows];
    cnt_word_t  blk_words [num_rows][3][6];
    ctl_block_t evt_q [$];
    ctl_block_t exp_q [$];

    logic       exp_mode;
    rate_t      exp_rate_i;
    rate_t      exp_rate_p;
    rate_t      exp_steps_i;
    rate_t      exp_steps_p;
    cnt_word_t  exp_fws;
    sync_time_t exp_time;
    base_cnt_t  exp_base;

    tb_clk_gen u_clk (.CLK(CLK));

    ctl_loader_top DUT (.*);

    function automatic cnt_word_t fill_word(input int a);
        return {8'(a) ^ 8'h5a, 8'(a)};
    endfunction

    // Control RAM that registers the address and then the data word
    always @(posedge CLK) begin
        if (!arst_n) begin
            for (int a = 0; a < 256; a++) begin
                mem[a] <= fill_word(a);
            end
            mem[`CTL_ADDR_CTL_FLAG] <= '0; // Host starts with no request
            rd_addr_q <= '0;
            rd_data_q <= '0;
        end else begin
            if (ram_we) begin
                mem[ram_addr] <= ram_din;
            end
            if (host_we) begin
                mem[host_addr] <= host_data;
            end
            rd_addr_q <= ram_addr;
            rd_data_q <= mem[rd_addr_q];
        end
    end

    // Read data reaches the DUT input 1 ns after the edge
    always @(posedge CLK) begin
        #1;
        ram_dout = rd_data_q;
    end

    always @(posedge CLK) begin
        if (arst_n) begin
            if (silencer_update) evt_q.push_back(BLK_SILENCER);
            if (pwe_update) evt_q.push_back(BLK_PWE);
            if (sync_update) evt_q.push_back(BLK_SYNC);
        end
    end

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            end_in_failure();
        end
    end

    task automatic end_in_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string what, input cnt_word_t got, input cnt_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_rate(input string what, input rate_t got, input rate_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_time(input string what, input sync_time_t got, input sync_time_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_base(input string what, input base_cnt_t got, input base_cnt_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_block(input string what, input ctl_block_t got, input ctl_block_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %s, expected %s", $time, what,
                     got.name(), exp.name());
            end_in_failure();
        end
    endtask

    task automatic build_table();
        rows[0] = '{flags: '0, thermo: 1'b1, exp_blk: 3'b000}; // Status only
        rows[1] = '{flags: f_sil, thermo: 1'b1, exp_blk: 3'b001};
        rows[2] = '{flags: f_pwe, thermo: 1'b0, exp_blk: 3'b010};
        rows[3] = '{flags: f_sync, thermo: 1'b0, exp_blk: 3'b100};
        rows[4] = '{flags: f_fan, thermo: 1'b1, exp_blk: 3'b000};
        rows[5] = '{flags: set_mask | f_fan, thermo: 1'b0, exp_blk: 3'b111};
        rows[6] = '{flags: f_pwe | f_sync | f_fan, thermo: 1'b1, exp_blk: 3'b110};
        rows[7] = '{flags: f_sil | f_sync, thermo: 1'b0, exp_blk: 3'b101}; // Fan released
    endtask

    // Called 1 ns after a rising edge and returns at the same point of the next cycle
    task automatic host_write(input cnt_addr_t addr, input cnt_word_t data);
        host_we   = 1'b1;
        host_addr = addr;
        host_data = data;
        @(posedge CLK);
        #1;
        host_we = 1'b0;
    endtask

    task automatic wait_ram(input cnt_addr_t addr, input cnt_word_t exp, input string what);
        int n;
        n = 0;
        while (mem[addr] !== exp && n < poll_window) begin
            @(posedge CLK);
            #1;
            n++;
        end
        check_word(what, mem[addr], exp);
    endtask

    task automatic wait_fan(input logic exp);
        int n;
        n = 0;
        while (force_fan !== exp && n < poll_window) begin
            @(posedge CLK);
            #1;
            n++;
        end
        check_bit("force_fan", force_fan, exp);
    endtask

    // Puts the block's words into RAM and assembles the fields they should give
    task automatic load_block(input int r, input ctl_block_t blk);
        cnt_addr_t base;
        int        len;
        int        k;
        k = int'(blk);
        case (blk)
            BLK_SILENCER: begin
                base        = `CTL_ADDR_SILENCER_BASE;
                len         = int'(`CTL_LEN_SILENCER);
                exp_mode    = blk_words[r][k][0][0];
                exp_rate_i  = blk_words[r][k][1];
                exp_rate_p  = blk_words[r][k][2];
                exp_steps_i = blk_words[r][k][3];
                exp_steps_p = blk_words[r][k][4];
            end
            BLK_PWE: begin
                base    = `CTL_ADDR_PWE_BASE;
                len     = int'(`CTL_LEN_PWE);
                exp_fws = blk_words[r][k][0];
            end
            default: begin
                base     = `CTL_ADDR_SYNC_BASE;
                len      = int'(`CTL_LEN_SYNC);
                exp_time = {blk_words[r][k][3], blk_words[r][k][2],
                            blk_words[r][k][1], blk_words[r][k][0]};
                exp_base = {blk_words[r][k][5], blk_words[r][k][4]};
            end
        endcase
        for (int i = 0; i < len; i++) begin
            host_write(base + cnt_addr_t'(i), blk_words[r][k][i]);
        end
        exp_q.push_back(blk);
    endtask

    task automatic compare_fields();
        check_bit("silencer_mode", silencer_mode, exp_mode);
        check_rate("silencer_rate_intensity", silencer_rate_intensity, exp_rate_i);
        check_rate("silencer_rate_phase", silencer_rate_phase, exp_rate_p);
        check_rate("silencer_steps_intensity", silencer_steps_intensity, exp_steps_i);
        check_rate("silencer_steps_phase", silencer_steps_phase, exp_steps_p);
        check_word("pwe_full_width_start", pwe_full_width_start, exp_fws);
        check_time("sync_time", sync_time, exp_time);
        check_base("sync_base_cnt", sync_base_cnt, exp_base);
    endtask

    task automatic compare_events();
        check_word("update strobe count", cnt_word_t'(evt_q.size()), cnt_word_t'(exp_q.size()));
        for (int i = 0; i < exp_q.size(); i++) begin
            check_block($sformatf("update strobe %0d", i), evt_q[i], exp_q[i]);
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        row    = rows[r];
        thermo = row.thermo;
        if (row.exp_blk[0]) load_block(r, BLK_SILENCER);
        if (row.exp_blk[1]) load_block(r, BLK_PWE);
        if (row.exp_blk[2]) load_block(r, BLK_SYNC);
        host_write(`CTL_ADDR_CTL_FLAG, row.flags); // The request goes in last
        while (evt_q.size() < exp_q.size()) begin
            @(posedge CLK);
            #1;
        end
        compare_fields();
        wait_ram(`CTL_ADDR_CTL_FLAG, row.flags & ~set_mask, "flag word after acknowledge");
        wait_ram(`CTL_ADDR_FPGA_STATE, {15'h0000, row.thermo}, "status word");
        wait_fan(row.flags[`CTL_FLAG_FORCE_FAN]);
        compare_events();
    endtask

    initial begin
        arst_n = 1'b0;
        thermo = 1'b0;
        void'($urandom(32'h96a9));
        build_table();
        for (int r = 0; r < num_rows; r++) begin
            for (int b = 0; b < 3; b++) begin
                for (int i = 0; i < 6; i++) begin
                    blk_words[r][b][i] = cnt_word_t'($urandom());
                end
            end
        end
        exp_mode    = `CTL_DEF_SILENCER_MODE;
        exp_rate_i  = `CTL_DEF_RATE_INTENSITY;
        exp_rate_p  = `CTL_DEF_RATE_PHASE;
        exp_steps_i = `CTL_DEF_STEPS_INTENSITY;
        exp_steps_p = `CTL_DEF_STEPS_PHASE;
        exp_fws     = `CTL_DEF_FULL_WIDTH;
        exp_time    = `CTL_DEF_SYNC_TIME;
        exp_base    = `CTL_DEF_BASE_CNT;
        repeat (8) @(posedge CLK);
        #1;
        arst_n = 1'b1;
        wait_ram(`CTL_ADDR_VER_MINOR, `CTL_VER_MINOR, "minor version word");
        wait_ram(`CTL_ADDR_VER_MAJOR, `CTL_VER_MAJOR, "major version word");
        compare_fields();
        check_bit("force_fan after reset", force_fan, 1'b0);
        check_word("update strobes after reset", cnt_word_t'(evt_q.size()), '0);
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns = 10
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever #(period_ns / 2) CLK = ~CLK;
    end

endmodule

// ==== source/ctl_loader_top.sv ====
`timescale 1ns/1ps

module ctl_loader_top import ctl_loader_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       thermo,
    input  cnt_word_t  ram_dout,
    output logic       ram_we,
    output cnt_addr_t  ram_addr,
    output cnt_word_t  ram_din,
    output logic       force_fan,
    output logic       silencer_mode,
    output rate_t      silencer_rate_intensity,
    output rate_t      silencer_rate_phase,
    output rate_t      silencer_steps_intensity,
    output rate_t      silencer_steps_phase,
    output logic       silencer_update,
    output cnt_word_t  pwe_full_width_start,
    output logic       pwe_update,
    output sync_time_t sync_time,
    output base_cnt_t  sync_base_cnt,
    output logic       sync_update
);

    ctl_flags_t flags;
    logic       pending;
    ctl_block_t pending_blk;

    ctl_seq_if seq ();

    ctl_fsm u_fsm (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .pending     (pending),
        .pending_blk (pending_blk),
        .seq         (seq.fsm)
    );

    burst_counter u_counter (
        .CLK    (CLK),
        .arst_n (arst_n),
        .seq    (seq.counter)
    );

    ctl_flag_reg u_flags (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .ram_dout    (ram_dout),
        .seq         (seq.capture),
        .flags       (flags),
        .pending     (pending),
        .pending_blk (pending_blk),
        .force_fan   (force_fan)
    );

    settings_capture u_capture (
        .CLK                      (CLK),
        .arst_n                   (arst_n),
        .ram_dout                 (ram_dout),
        .seq                      (seq.capture),
        .silencer_mode            (silencer_mode),
        .silencer_rate_intensity  (silencer_rate_intensity),
        .silencer_rate_phase      (silencer_rate_phase),
        .silencer_steps_intensity (silencer_steps_intensity),
        .silencer_steps_phase     (silencer_steps_phase),
        .silencer_update          (silencer_update),
        .pwe_full_width_start     (pwe_full_width_start),
        .pwe_update               (pwe_update),
        .sync_time                (sync_time),
        .sync_base_cnt            (sync_base_cnt),
        .sync_update              (sync_update)
    );

    ctl_bus_port u_bus (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .thermo   (thermo),
        .flags    (flags),
        .seq      (seq.bus),
        .ram_we   (ram_we),
        .ram_addr (ram_addr),
        .ram_din  (ram_din)
    );

endmodule

// ==== source/ctl_bus_port.sv ====
`timescale 1ns/1ps
`include "ctl_loader_settings.svh"

module ctl_bus_port import ctl_loader_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       thermo,
    input  ctl_flags_t flags,
    ctl_seq_if.bus     seq,
    output logic       ram_we,
    output cnt_addr_t  ram_addr,
    output cnt_word_t  ram_din
);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            ram_we   <= 1'b0;
            ram_addr <= '0;
            ram_din  <= '0;
        end else begin
            ram_we <= 1'b0;
            case (seq.phase)
                PH_VER_MINOR: begin
                    ram_we   <= 1'b1;
                    ram_addr <= `CTL_ADDR_VER_MINOR;
                    ram_din  <= `CTL_VER_MINOR;
                end
                PH_VER_MAJOR: begin
                    ram_we   <= 1'b1;
                    ram_addr <= `CTL_ADDR_VER_MAJOR;
                    ram_din  <= `CTL_VER_MAJOR;
                end
                PH_READ_FLAG: ram_addr <= `CTL_ADDR_CTL_FLAG;
                PH_STATUS: begin
                    ram_we   <= 1'b1;
                    ram_addr <= `CTL_ADDR_FPGA_STATE;
                    ram_din  <= {15'h0000, thermo}; // Only the thermal bit is defined
                end
                PH_BURST: ram_addr <= blk_base(seq.blk) + cnt_addr_t'(seq.req_idx);
                PH_UPDATE: begin
                    ram_we   <= 1'b1;
                    ram_addr <= `CTL_ADDR_CTL_FLAG;
                    ram_din  <= flags; // Served bit is already cleared
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== source/settings_capture.sv ====
`timescale 1ns/1ps
`include "ctl_loader_settings.svh"

module settings_capture import ctl_loader_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    input  cnt_word_t  ram_dout,
    ctl_seq_if.capture seq,
    output logic       silencer_mode,
    output rate_t      silencer_rate_intensity,
    output rate_t      silencer_rate_phase,
    output rate_t      silencer_steps_intensity,
    output rate_t      silencer_steps_phase,
    output logic       silencer_update,
    output cnt_word_t  pwe_full_width_start,
    output logic       pwe_update,
    output sync_time_t sync_time,
    output base_cnt_t  sync_base_cnt,
    output logic       sync_update
);

    logic [5:0] time_lsb;
    logic [4:0] base_lsb;

    // Low word first, so the word index picks the 16-bit slice
    assign time_lsb = {seq.cap_idx[1:0], 4'b0000};
    assign base_lsb = {seq.cap_idx[0], 4'b0000};

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            silencer_mode            <= `CTL_DEF_SILENCER_MODE;
            silencer_rate_intensity  <= `CTL_DEF_RATE_INTENSITY;
            silencer_rate_phase      <= `CTL_DEF_RATE_PHASE;
            silencer_steps_intensity <= `CTL_DEF_STEPS_INTENSITY;
            silencer_steps_phase     <= `CTL_DEF_STEPS_PHASE;
            pwe_full_width_start     <= `CTL_DEF_FULL_WIDTH;
            sync_time                <= `CTL_DEF_SYNC_TIME;
            sync_base_cnt            <= `CTL_DEF_BASE_CNT;
        end else if (seq.cap_valid) begin
            case (seq.blk)
                BLK_SILENCER: begin
                    case (seq.cap_idx)
                        3'd0:    silencer_mode            <= ram_dout[0];
                        3'd1:    silencer_rate_intensity  <= ram_dout;
                        3'd2:    silencer_rate_phase      <= ram_dout;
                        3'd3:    silencer_steps_intensity <= ram_dout;
                        default: silencer_steps_phase     <= ram_dout;
                    endcase
                end
                BLK_PWE: begin
                    pwe_full_width_start <= ram_dout; // Single word block
                end
                BLK_SYNC: begin
                    // Words 0 to 3 carry the time, 4 and 5 the base count
                    if (seq.cap_idx < 3'd4) begin
                        sync_time[time_lsb +: 16] <= ram_dout;
                    end else begin
                        sync_base_cnt[base_lsb +: 16] <= ram_dout;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Strobes come from the registered phase and last exactly one cycle
    assign silencer_update = (seq.phase == PH_UPDATE) && (seq.blk == BLK_SILENCER);
    assign pwe_update      = (seq.phase == PH_UPDATE) && (seq.blk == BLK_PWE);
    assign sync_update     = (seq.phase == PH_UPDATE) && (seq.blk == BLK_SYNC);

endmodule

// ==== source/ctl_flag_reg.sv ====
`timescale 1ns/1ps
`include "ctl_loader_settings.svh"

module ctl_flag_reg import ctl_loader_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    input  cnt_word_t  ram_dout,
    ctl_seq_if.capture seq,
    output ctl_flags_t flags,
    output logic       pending,
    output ctl_block_t pending_blk,
    output logic       force_fan
);

    ctl_flags_t flags_view;

    // In the latch cycle the word is still on the RAM port
    assign flags_view = (seq.phase == PH_LATCH) ? ram_dout : flags;

    always_comb begin
        pending     = 1'b1;
        pending_blk = BLK_SILENCER;
        if (flags_view[`CTL_FLAG_SILENCER_SET]) begin
            pending_blk = BLK_SILENCER;
        end else if (flags_view[`CTL_FLAG_PWE_SET]) begin
            pending_blk = BLK_PWE;
        end else if (flags_view[`CTL_FLAG_SYNC_SET]) begin
            pending_blk = BLK_SYNC;
        end else begin
            pending = 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (seq.phase == PH_LATCH) begin
            flags <= ram_dout;
        end else if (seq.phase == PH_BURST && seq.req_idx == '0) begin
            flags <= flags & ~blk_flag_mask(seq.blk); // Written back as the acknowledge
        end
    end

    assign force_fan = flags[`CTL_FLAG_FORCE_FAN];

endmodule

// ==== source/burst_counter.sv ====
`timescale 1ns/1ps
`include "ctl_loader_settings.svh"

module burst_counter import ctl_loader_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    ctl_seq_if.counter seq
);

    localparam int LAT = `CTL_RD_LATENCY;

    burst_idx_t           req_idx;
    logic                 req_on;
    logic                 req_last;
    logic [LAT-1:0]       vld_pipe;
    logic [LAT-1:0]       last_pipe;
    burst_idx_t           idx_pipe [LAT];

    assign req_on   = (seq.phase == PH_BURST);
    assign req_last = (burst_idx_t'(req_idx + 3'd1) == blk_len(seq.blk));

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            req_idx   <= '0;
            vld_pipe  <= '0;
            last_pipe <= '0;
        end else begin
            if (req_on && !req_last) begin
                req_idx <= req_idx + 3'd1;
            end else begin
                req_idx <= '0;
            end
            vld_pipe  <= {vld_pipe[LAT-2:0], req_on};
            last_pipe <= {last_pipe[LAT-2:0], req_on && req_last};
        end
    end

    // Up to LAT reads are in flight, each index travels with its valid bit
    always_ff @(posedge CLK) begin
        idx_pipe[0] <= req_idx;
        for (int i = 1; i < LAT; i++) begin
            idx_pipe[i] <= idx_pipe[i-1];
        end
    end

    assign seq.req_idx   = req_idx;
    assign seq.cap_idx   = idx_pipe[LAT-1];
    assign seq.cap_valid = vld_pipe[LAT-1];
    assign seq.last_cap  = last_pipe[LAT-1];

endmodule

// ==== source/ctl_fsm.sv ====
`timescale 1ns/1ps

module ctl_fsm import ctl_loader_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       pending,
    input  ctl_block_t pending_blk,
    ctl_seq_if.fsm     seq
);

    ctl_phase_t phase;
    ctl_phase_t phase_nxt;
    ctl_block_t blk;
    logic       burst_done;

    // The counter shows the index of the word requested in this cycle
    assign burst_done = (burst_idx_t'(seq.req_idx + 3'd1) == blk_len(blk));

    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_VER_MINOR: phase_nxt = PH_VER_MAJOR;
            PH_VER_MAJOR: phase_nxt = PH_READ_FLAG;
            PH_READ_FLAG: phase_nxt = PH_STATUS;
            PH_STATUS:    phase_nxt = PH_WAIT_FLAG;
            PH_WAIT_FLAG: phase_nxt = PH_LATCH;
            PH_LATCH: begin
                if (pending) begin
                    phase_nxt = PH_BURST;
                end else begin
                    phase_nxt = PH_READ_FLAG;
                end
            end
            PH_BURST: begin
                if (burst_done) begin
                    phase_nxt = PH_DRAIN;
                end
            end
            PH_DRAIN: begin
                if (seq.last_cap) begin // Last word lands in this cycle
                    phase_nxt = PH_UPDATE;
                end
            end
            PH_UPDATE:    phase_nxt = PH_READ_FLAG;
            default:      phase_nxt = PH_READ_FLAG;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            phase <= PH_VER_MINOR;
        end else begin
            phase <= phase_nxt;
        end
    end

    // The block is fixed for the whole burst, drain and update
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            blk <= BLK_SILENCER;
        end else if (phase == PH_LATCH && pending) begin
            blk <= pending_blk;
        end
    end

    assign seq.phase = phase;
    assign seq.blk   = blk;

endmodule

// ==== source/ctl_seq_if.sv ====
`timescale 1ns/1ps

interface ctl_seq_if import ctl_loader_pkg::*; ();

    ctl_phase_t phase;
    ctl_block_t blk;      // Block under load, valid from the first burst cycle
    burst_idx_t req_idx;  // Word requested in this cycle
    burst_idx_t cap_idx;  // Word on ram_dout in this cycle
    logic       cap_valid;
    logic       last_cap;

    modport fsm (
        output phase, blk,
        input  req_idx, last_cap
    );

    modport counter (
        input  phase, blk,
        output req_idx, cap_idx, cap_valid, last_cap
    );

    modport bus (input phase, blk, req_idx);

    modport capture (input phase, blk, req_idx, cap_idx, cap_valid);

endinterface

// ==== source/ctl_loader_pkg.sv ====
`include "ctl_loader_settings.svh"

package ctl_loader_pkg;

    typedef logic [15:0] cnt_word_t;
    typedef logic [7:0]  cnt_addr_t;
    typedef logic [15:0] ctl_flags_t;
    typedef logic [15:0] rate_t;
    typedef logic [63:0] sync_time_t;
    typedef logic [31:0] base_cnt_t;
    typedef logic [2:0]  burst_idx_t;

    typedef enum logic [3:0] {
        PH_VER_MINOR,
        PH_VER_MAJOR,
        PH_READ_FLAG,
        PH_STATUS,
        PH_WAIT_FLAG,
        PH_LATCH,
        PH_BURST,
        PH_DRAIN,
        PH_UPDATE
    } ctl_phase_t;

    typedef enum logic [1:0] {
        BLK_SILENCER,
        BLK_PWE,
        BLK_SYNC
    } ctl_block_t;

    function automatic burst_idx_t blk_len(input ctl_block_t blk);
        case (blk)
            BLK_PWE:  return `CTL_LEN_PWE;
            BLK_SYNC: return `CTL_LEN_SYNC;
            default:  return `CTL_LEN_SILENCER;
        endcase
    endfunction

    function automatic cnt_addr_t blk_base(input ctl_block_t blk);
        case (blk)
            BLK_PWE:  return `CTL_ADDR_PWE_BASE;
            BLK_SYNC: return `CTL_ADDR_SYNC_BASE;
            default:  return `CTL_ADDR_SILENCER_BASE;
        endcase
    endfunction

    // Set flag of a block as a one-hot mask over the flag word
    function automatic ctl_flags_t blk_flag_mask(input ctl_block_t blk);
        case (blk)
            BLK_PWE:  return ctl_flags_t'(1) << `CTL_FLAG_PWE_SET;
            BLK_SYNC: return ctl_flags_t'(1) << `CTL_FLAG_SYNC_SET;
            default:  return ctl_flags_t'(1) << `CTL_FLAG_SILENCER_SET;
        endcase
    endfunction

endpackage

// ==== include/ctl_loader_settings.svh ====
`ifndef CTL_LOADER_SETTINGS_SVH
`define CTL_LOADER_SETTINGS_SVH

// Fixed words of the control RAM
`define CTL_ADDR_CTL_FLAG       8'h00
`define CTL_ADDR_FPGA_STATE     8'h01
`define CTL_ADDR_VER_MAJOR      8'h02
`define CTL_ADDR_VER_MINOR      8'h03

// Each block occupies consecutive words from its base
`define CTL_ADDR_SILENCER_BASE  8'h40
`define CTL_ADDR_PWE_BASE       8'h50
`define CTL_ADDR_SYNC_BASE      8'h60

`define CTL_FLAG_SILENCER_SET   2
`define CTL_FLAG_PWE_SET        3
`define CTL_FLAG_SYNC_SET       5
`define CTL_FLAG_FORCE_FAN      13

`define CTL_LEN_SILENCER        3'd5
`define CTL_LEN_PWE             3'd1
`define CTL_LEN_SYNC            3'd6

// Request phase to sample cycle, one register stage plus two RAM cycles
`define CTL_RD_LATENCY          3

`define CTL_VER_MAJOR           16'h00A2
`define CTL_VER_MINOR           16'h0001

`define CTL_DEF_SILENCER_MODE   1'b0 // Fixed completion steps
`define CTL_DEF_RATE_INTENSITY  16'd256
`define CTL_DEF_RATE_PHASE      16'd256
`define CTL_DEF_STEPS_INTENSITY 16'd10
`define CTL_DEF_STEPS_PHASE     16'd40
`define CTL_DEF_FULL_WIDTH      16'd65025
`define CTL_DEF_SYNC_TIME       64'd0
`define CTL_DEF_BASE_CNT        32'd10240

`endif
